/* logic/lynx_loader_pkg.sv */
// Loader package for the handheld console download path
// Download file type codes, width types for the host, memory,
// BIOS and cheat paths, and the cartridge writer state encoding

package lynx_loader_pkg;

	////////////////////////////////////////////////////////////////////
	// Width types
	////////////////////////////////////////////////////////////////////

	typedef logic [7:0]   file_type_t;   // Download index from host menu
	typedef logic [24:0]  host_addr_t;   // Host byte address
	typedef logic [15:0]  host_word_t;   // Host download word
	typedef logic [23:0]  mem_addr_t;    // External memory word address
	typedef logic [19:0]  rom_size_t;    // Last cartridge byte address
	typedef logic [8:0]   bios_addr_t;
	typedef logic [7:0]   bios_byte_t;

	// Flags 127:96, address 95:64, compare 63:32, replace 31:0
	typedef logic [127:0] cheat_code_t;

	////////////////////////////////////////////////////////////////////
	// File types and loader constants
	////////////////////////////////////////////////////////////////////

	localparam file_type_t FT_BIOS   = 8'h00;
	localparam file_type_t FT_CART_A = 8'h01;
	localparam file_type_t FT_CART_B = 8'h41;
	localparam file_type_t FT_CART_C = 8'h80;
	localparam file_type_t FT_CHEAT  = 8'hFF;

	localparam logic [3:0] CHEAT_LAST_OFFSET = 4'd14; // Replace top word

	// Cartridge writer states
	typedef enum logic {
		cart_idle,
		cart_busy
	} cart_state_t;

	// Any of the three cartridge indices
	function automatic logic is_cart_type(input file_type_t ft);
		return (ft == FT_CART_A) || (ft == FT_CART_B) || (ft == FT_CART_C);
	endfunction

endpackage

/* logic/cart_loader.sv */
// Cartridge loader
// Forwards each cartridge download word to external memory over a
// request/acknowledge port and stalls the host with dl_wait until the
// memory has taken it. At the end of the download the last byte
// address is kept as the cartridge size and cart_ready is set.

`timescale 1ns/100ps

module cart_loader
	import lynx_loader_pkg::*;
(
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       dl_active,
	input  logic       dl_wr,
	input  file_type_t dl_type,
	input  host_addr_t dl_addr,
	input  host_word_t dl_data,
	input  logic       mem_ack,
	output logic       dl_wait,
	output logic       mem_req,
	output mem_addr_t  mem_addr,
	output host_word_t mem_data,
	output rom_size_t  rom_size,
	output logic       cart_ready
);

	cart_state_t state;
	logic        cart_dl;     // Cartridge download in progress
	logic        cart_dl_q;
	rom_size_t   last_addr;   // Byte address of the latest strobe

	assign cart_dl = dl_active && is_cart_type(dl_type);

	//////////////////////////////////////////////////////////////////////
	// Memory write handshake
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			state <= cart_idle;
		end else begin
			case (state)
				cart_idle: if (cart_dl && dl_wr) state <= cart_busy;
				cart_busy: if (mem_ack) state <= cart_idle;
				default: state <= cart_idle;
			endcase
		end
	end

	// Request and host stall share the busy state
	assign mem_req = (state == cart_busy);
	assign dl_wait = (state == cart_busy);

	// Word and address held stable for the whole request
	always_ff @(posedge clk_sys) begin
		if (state == cart_idle && cart_dl && dl_wr) begin
			mem_addr  <= dl_addr[24:1];    // Byte to word address
			mem_data  <= dl_data;
			last_addr <= dl_addr[19:0];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Cartridge size capture
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cart_dl_q  <= 1'b0;
			rom_size   <= '0;
			cart_ready <= 1'b0;
		end else begin
			cart_dl_q <= cart_dl;
			if (cart_dl_q && !cart_dl) begin   // End of download
				rom_size   <= last_addr;
				cart_ready <= 1'b1;              // Sticky until reset
			end
		end
	end

	// The host honours the stall
	a_no_wr_while_wait: assert property (@(posedge clk_sys) disable iff (!rst_n)
		dl_wait |-> !dl_wr);

endmodule

/* logic/bios_loader.sv */
// BIOS loader
// Splits each 16-bit BIOS download word into two byte writes on
// consecutive cycles, low byte first and high byte at the next address

`timescale 1ns/100ps

module bios_loader
	import lynx_loader_pkg::*;
(
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       dl_active,
	input  logic       dl_wr,
	input  file_type_t dl_type,
	input  host_addr_t dl_addr,
	input  host_word_t dl_data,
	output logic       bios_wr,
	output bios_addr_t bios_addr,
	output bios_byte_t bios_data
);

	logic       bios_strobe;
	logic       pending;     // High byte still to be written
	bios_byte_t hi_byte;

	assign bios_strobe = dl_active && (dl_type == FT_BIOS) && dl_wr;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			bios_wr <= 1'b0;
			pending <= 1'b0;
		end else begin
			bios_wr <= bios_strobe || pending;
			pending <= bios_strobe;
		end
	end

	// Byte lanes and address
	always_ff @(posedge clk_sys) begin
		if (bios_strobe) begin
			bios_addr <= dl_addr[8:0];
			bios_data <= dl_data[7:0];
			hi_byte   <= dl_data[15:8];    // Kept for the second write
		end else if (pending) begin
			bios_addr <= bios_addr + 1'b1;
			bios_data <= hi_byte;
		end
	end

	// Host leaves an idle cycle between BIOS strobes
	a_no_strobe_pending: assert property (@(posedge clk_sys) disable iff (!rst_n)
		pending |-> !bios_strobe);

endmodule

/* logic/cheat_loader.sv */
// Cheat loader
// Assembles 128-bit cheat codes from the download stream. A clear
// pulse marks the start of a cheat download and a valid pulse follows
// the last word of each code.

`timescale 1ns/100ps

module cheat_loader
	import lynx_loader_pkg::*;
(
	input  logic        clk_sys,
	input  logic        rst_n,
	input  logic        dl_active,
	input  logic        dl_wr,
	input  file_type_t  dl_type,
	input  host_addr_t  dl_addr,
	input  host_word_t  dl_data,
	output cheat_code_t cheat_code,
	output logic        cheat_valid,
	output logic        cheat_clear
);

	logic       active_q;
	logic       cheat_strobe;
	logic [3:0] offset;        // Byte offset within one code

	assign cheat_strobe = dl_active && (dl_type == FT_CHEAT) && dl_wr;
	assign offset       = dl_addr[3:0];

	//////////////////////////////////////////////////////////////////////
	// Clear and valid pulses
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			active_q    <= 1'b0;
			cheat_clear <= 1'b0;
			cheat_valid <= 1'b0;
		end else begin
			active_q    <= dl_active;
			cheat_clear <= dl_active && !active_q && (dl_type == FT_CHEAT);
			cheat_valid <= cheat_strobe && (offset == CHEAT_LAST_OFFSET);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Code assembly
	//////////////////////////////////////////////////////////////////////

	// Bottom word of each field arrives first
	always_ff @(posedge clk_sys) begin
		if (cheat_strobe) begin
			case (offset)
				4'd0:  cheat_code[111:96]  <= dl_data; // Flags
				4'd2:  cheat_code[127:112] <= dl_data;
				4'd4:  cheat_code[79:64]   <= dl_data; // Address
				4'd6:  cheat_code[95:80]   <= dl_data;
				4'd8:  cheat_code[47:32]   <= dl_data; // Compare
				4'd10: cheat_code[63:48]   <= dl_data;
				4'd12: cheat_code[15:0]    <= dl_data; // Replace
				4'd14: cheat_code[31:16]   <= dl_data;
				default: ;                              // Odd offsets carry nothing
			endcase
		end
	end

endmodule

/* logic/ff_latch.sv */
// Fast-forward control
// A short tap of the button toggles a latched fast-forward, a long
// hold runs fast-forward only while the button stays down. Presses
// during a download or with the OSD open are ignored.

`timescale 1ns/100ps

module ff_latch #(
	parameter int HOLD_LIMIT = 6400000    // Cycles, shorter press is a tap
) (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic ff_button,
	input  logic dl_active,
	input  logic osd_open,
	output logic fast_forward
);

	localparam int CNT_W = $clog2(HOLD_LIMIT + 1);

	logic             held;
	logic             held_q;
	logic             press;
	logic             release_tap;
	logic             latch;
	logic             latch_nxt;
	logic             was_latched;  // Previous release set the latch
	logic [CNT_W-1:0] hold_cnt;

	assign held        = ff_button && !dl_active && !osd_open;
	assign press       = held && !held_q;
	assign release_tap = !held && held_q && (hold_cnt < CNT_W'(HOLD_LIMIT)) && !was_latched;

	assign latch_nxt = press ? 1'b0 : (release_tap ? 1'b1 : latch);

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			held_q       <= 1'b0;
			hold_cnt     <= '0;
			latch        <= 1'b0;
			was_latched  <= 1'b0;
			fast_forward <= 1'b0;
		end else begin
			held_q <= held;
			latch  <= latch_nxt;

			if (press)
				hold_cnt <= '0;                       // New press restarts timing
			else if (held && hold_cnt != CNT_W'(HOLD_LIMIT))
				hold_cnt <= hold_cnt + 1'b1;          // Saturates at the limit

			if (!held && held_q)
				was_latched <= release_tap;           // Taps alternate on and off

			fast_forward <= held || latch_nxt;
		end
	end

endmodule

/* logic/lynx_loader_top.sv */
// Loader top level
// Connects the cartridge, BIOS and cheat loaders and the fast-forward
// control to the host download port, the memory port and the core

`timescale 1ns/100ps

module lynx_loader_top
	import lynx_loader_pkg::*;
#(
	parameter int HOLD_LIMIT = 6400000    // 0.1 s at 64 MHz
) (
	input  logic        clk_sys,
	input  logic        rst_n,

	// Host download port
	input  logic        dl_active,
	input  file_type_t  dl_type,
	input  logic        dl_wr,
	input  host_addr_t  dl_addr,
	input  host_word_t  dl_data,
	output logic        dl_wait,

	// External memory
	output logic        mem_req,
	output mem_addr_t   mem_addr,
	output host_word_t  mem_data,
	input  logic        mem_ack,

	// Core side
	output logic        bios_wr,
	output bios_addr_t  bios_addr,
	output bios_byte_t  bios_data,
	output rom_size_t   rom_size,
	output logic        cart_ready,
	output cheat_code_t cheat_code,
	output logic        cheat_valid,
	output logic        cheat_clear,
	output logic        fast_forward,
	input  logic        ff_button,
	input  logic        osd_open
);

	cart_loader u_cart (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.dl_active  (dl_active),
		.dl_wr      (dl_wr),
		.dl_type    (dl_type),
		.dl_addr    (dl_addr),
		.dl_data    (dl_data),
		.mem_ack    (mem_ack),
		.dl_wait    (dl_wait),
		.mem_req    (mem_req),
		.mem_addr   (mem_addr),
		.mem_data   (mem_data),
		.rom_size   (rom_size),
		.cart_ready (cart_ready)
	);

	bios_loader u_bios (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.dl_active (dl_active),
		.dl_wr     (dl_wr),
		.dl_type   (dl_type),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.bios_wr   (bios_wr),
		.bios_addr (bios_addr),
		.bios_data (bios_data)
	);

	cheat_loader u_cheat (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.dl_active   (dl_active),
		.dl_wr       (dl_wr),
		.dl_type     (dl_type),
		.dl_addr     (dl_addr),
		.dl_data     (dl_data),
		.cheat_code  (cheat_code),
		.cheat_valid (cheat_valid),
		.cheat_clear (cheat_clear)
	);

	ff_latch #(
		.HOLD_LIMIT (HOLD_LIMIT)
	) u_ff (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.ff_button    (ff_button),
		.dl_active    (dl_active),
		.osd_open     (osd_open),
		.fast_forward (fast_forward)
	);

endmodule

/* verification/loader_tb_ref.svh */
// Reference model for the loader testbench
// Expected memory words, BIOS byte writes, cheat codes and the
// fast-forward level, all worked out from the loader rules

`ifndef LOADER_TB_REF_SVH
`define LOADER_TB_REF_SVH

// Outstanding expectations, oldest first
host_addr_t  mem_addr_q[$];
host_word_t  mem_data_q[$];
logic [16:0] bios_q[$];         // {address, byte}
cheat_code_t cheat_q[$];

// Fast-forward press history
logic ff_held;                  // Button counts as held
int   ff_taps;                  // Taps since the last long hold

////////////////////////////////////////////////////////////////////////
// Reference functions
////////////////////////////////////////////////////////////////////////

// Word address is the byte address without the byte select
function automatic mem_addr_t exp_mem_addr(input host_addr_t a);
	return a[24:1];
endfunction

// One of the two byte writes of a BIOS word, hi picks the second
function automatic logic [16:0] bios_expect(input host_addr_t a,
		input host_word_t d, input logic hi);
	bios_addr_t ba;
	bios_byte_t bb;
	ba = a[8:0] + 9'(hi);
	bb = hi ? d[15:8] : d[7:0];
	return {ba, bb};
endfunction

// Words in arrival order, word i at bits 16*i+15..16*i
// Each field gets its bottom word first
function automatic cheat_code_t cheat_assemble(input logic [127:0] w);
	logic [31:0] flags;
	logic [31:0] addr;
	logic [31:0] cmp;
	logic [31:0] repl;
	flags = {w[31:16], w[15:0]};
	addr  = {w[63:48], w[47:32]};
	cmp   = {w[95:80], w[79:64]};
	repl  = {w[127:112], w[111:96]};
	return {flags, addr, cmp, repl};
endfunction

// Held runs it, an odd number of taps since a long hold latches it
function automatic logic ff_expect(input logic held, input int taps);
	return held || ((taps % 2) == 1);
endfunction

`endif

/* verification/loader_tb.sv */
// Loader testbench
// Runs cartridge, BIOS and cheat downloads and the fast-forward button
// through the loader top level. A random-latency memory answers the
// cartridge requests and a monitor compares every core-side write.

`timescale 1ns/100ps

module loader_tb
	import lynx_loader_pkg::*;
;

	localparam int TB_HOLD     = 40;
	localparam int CART_WORDS  = 24;
	localparam int BIOS_WORDS  = 8;
	localparam int CHEAT_CODES = 2;
	localparam int ACK_TIMEOUT = 20;          // Cycles per cartridge word
	localparam file_type_t IDLE_TYPE = 8'h10; // Index no loader decodes

	// Worst case length of each test in cycles plus margin
	localparam int RUN_CYCLES = 10 + CART_WORDS * 10 + BIOS_WORDS * 3
		+ CHEAT_CODES * 16 + 2 * (TB_HOLD + 25) + 6 * 15 + 300;

	logic        clk_sys;
	logic        rst_n;
	logic        dl_active;
	file_type_t  dl_type;
	logic        dl_wr;
	host_addr_t  dl_addr;
	host_word_t  dl_data;
	logic        dl_wait;
	logic        mem_req;
	mem_addr_t   mem_addr;
	host_word_t  mem_data;
	logic        mem_ack;
	logic        bios_wr;
	bios_addr_t  bios_addr;
	bios_byte_t  bios_data;
	rom_size_t   rom_size;
	logic        cart_ready;
	cheat_code_t cheat_code;
	logic        cheat_valid;
	logic        cheat_clear;
	logic        fast_forward;
	logic        ff_button;
	logic        osd_open;

	int          seed;
	logic [31:0] rnd;
	logic [31:0] ack_rnd;
	int          errors;
	int          test_base;
	int          tests_done;
	int          clear_count;

	host_addr_t  cart_addr [CART_WORDS];
	host_word_t  cart_data [CART_WORDS];
	host_word_t  bios_word [BIOS_WORDS];
	logic [127:0] cheat_words [CHEAT_CODES];

	`include "loader_tb_ref.svh"

	lynx_loader_top #(.HOLD_LIMIT(TB_HOLD)) UUT (.*);

	initial clk_sys = 1'b0;
	always #10 clk_sys = ~clk_sys;

	////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////

	task automatic step();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic flag_mismatch(input string name, input string expv, input string got);
		$display("ERR %0t %s expected %s got %s", $time, name, expv, got);
		errors++;
	endtask

	task automatic note_failure(input string msg);
		$display("Failure at %0t: %s", $time, msg);
		errors++;
	endtask

	task automatic report_test(input string name);
		tests_done++;
		$display("Test %0d %s done, %0d errors", tests_done, name, errors - test_base);
		test_base = errors;
	endtask

	// One strobe with dl_wr low again on return
	task automatic host_write(input host_addr_t a, input host_word_t d);
		dl_addr = a;
		dl_data = d;
		dl_wr   = 1'b1;
		step();
		dl_wr   = 1'b0;
	endtask

	task automatic wait_cart_ack();
		int n;
		n = 0;
		if (!dl_wait)
			note_failure("dl_wait did not rise after a cartridge strobe");
		while (dl_wait && n < ACK_TIMEOUT) begin
			step();
			n++;
		end
		if (dl_wait)
			note_failure("dl_wait stuck high, host never released");
	endtask

	task automatic press_button(input int cycles, input logic counted);
		ff_button = 1'b1;
		step();
		if (counted)
			ff_held = 1'b1;                   // Output follows one edge later
		repeat (cycles - 1) step();
		ff_button = 1'b0;
		step();
		ff_held = 1'b0;
		if (counted) begin
			if (cycles < TB_HOLD)
				ff_taps++;
			else
				ff_taps = 0;                  // Long hold leaves it unlatched
		end
		repeat (4) step();
	endtask

	////////////////////////////////////////////////////////////////////
	// Memory responder and watchdog
	////////////////////////////////////////////////////////////////////

	initial begin : mem_responder
		logic [2:0] delay;
		mem_ack = 1'b0;
		forever begin
			step();
			if (mem_req) begin
				ack_rnd = $random(seed);
				delay   = 3'(ack_rnd % 32'd6);  // 0 to 5 cycles
				repeat (delay) step();
				mem_ack = 1'b1;
				step();
				mem_ack = 1'b0;
			end
		end
	end

	initial begin : watchdog
		repeat (RUN_CYCLES) @(posedge clk_sys);
		$display("Watchdog expired after %0d cycles", RUN_CYCLES);
		$display("Some tests failed");
		$finish;
	end

	////////////////////////////////////////////////////////////////////
	// Monitor sampling outputs mid-cycle
	////////////////////////////////////////////////////////////////////

	always @(negedge clk_sys) begin : monitor
		host_addr_t  a;
		host_word_t  d;
		logic [16:0] pair;
		cheat_code_t code;
		if (rst_n) begin
			if (mem_req && mem_ack) begin
				if (mem_addr_q.size() == 0) begin
					note_failure("memory acknowledge with no cartridge word outstanding");
				end else begin
					a = mem_addr_q.pop_front();
					d = mem_data_q.pop_front();
					if (mem_addr !== exp_mem_addr(a))
						flag_mismatch("mem_addr", $sformatf("%h", exp_mem_addr(a)),
							$sformatf("%h", mem_addr));
					if (mem_data !== d)
						flag_mismatch("mem_data", $sformatf("%h", d), $sformatf("%h", mem_data));
				end
			end
			if (bios_wr) begin
				if (bios_q.size() == 0) begin
					note_failure("bios_wr with no byte write expected");
				end else begin
					pair = bios_q.pop_front();
					if (bios_addr !== pair[16:8])
						flag_mismatch("bios_addr", $sformatf("%h", pair[16:8]),
							$sformatf("%h", bios_addr));
					if (bios_data !== pair[7:0])
						flag_mismatch("bios_data", $sformatf("%h", pair[7:0]),
							$sformatf("%h", bios_data));
				end
			end
			if (cheat_valid) begin
				if (cheat_q.size() == 0) begin
					note_failure("cheat_valid with no code expected");
				end else begin
					code = cheat_q.pop_front();
					if (cheat_code !== code)
						flag_mismatch("cheat_code", $sformatf("%h", code),
							$sformatf("%h", cheat_code));
				end
			end
			if (cheat_clear)
				clear_count++;
			if (fast_forward !== ff_expect(ff_held, ff_taps))
				flag_mismatch("fast_forward", $sformatf("%b", ff_expect(ff_held, ff_taps)),
					$sformatf("%b", fast_forward));
		end
	end

	////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////

	initial begin : stimulus
		rst_n = 1'b0;
		dl_active = 1'b0;
		dl_type = IDLE_TYPE;
		dl_wr = 1'b0;
		dl_addr = '0;
		dl_data = '0;
		ff_button = 1'b0;
		osd_open = 1'b0;
		ff_held = 1'b0;
		ff_taps = 0;
		errors = 0;
		test_base = 0;
		tests_done = 0;
		clear_count = 0;
		seed = 32'h85b2fc55;

		// All random stimulus drawn up front
		for (int i = 0; i < CART_WORDS; i++) begin
			rnd = $random(seed);
			cart_addr[i] = rnd[24:0];
			rnd = $random(seed);
			cart_data[i] = rnd[15:0];
		end
		for (int i = 0; i < BIOS_WORDS; i++) begin
			rnd = $random(seed);
			bios_word[i] = rnd[15:0];
		end
		for (int c = 0; c < CHEAT_CODES; c++) begin
			for (int j = 0; j < 4; j++) begin
				rnd = $random(seed);
				cheat_words[c][32*j +: 32] = rnd;
			end
		end

		repeat (2) @(posedge clk_sys);
		#1;
		rst_n = 1'b1;
		if (dl_wait || mem_req || bios_wr || cheat_valid || cheat_clear
				|| cart_ready || fast_forward)
			note_failure("outputs not all low after reset");

		// Cartridge words through the memory port
		dl_type = FT_CART_B;
		dl_active = 1'b1;
		step();
		for (int i = 0; i < CART_WORDS; i++) begin
			mem_addr_q.push_back(cart_addr[i]);
			mem_data_q.push_back(cart_data[i]);
			host_write(cart_addr[i], cart_data[i]);
			wait_cart_ack();
		end
		if (mem_addr_q.size() != 0)
			note_failure("cartridge words never reached memory");
		report_test("cartridge download");

		// Size capture at the end of the download
		dl_active = 1'b0;
		step();
		if (rom_size !== cart_addr[CART_WORDS-1][19:0])
			flag_mismatch("rom_size", $sformatf("%h", cart_addr[CART_WORDS-1][19:0]),
				$sformatf("%h", rom_size));
		if (cart_ready !== 1'b1)
			flag_mismatch("cart_ready", "1", $sformatf("%b", cart_ready));
		report_test("cartridge size");

		// BIOS words split into byte pairs
		dl_type = FT_BIOS;
		dl_active = 1'b1;
		step();
		for (int i = 0; i < BIOS_WORDS; i++) begin
			bios_q.push_back(bios_expect(host_addr_t'(256 + 2 * i), bios_word[i], 1'b0));
			bios_q.push_back(bios_expect(host_addr_t'(256 + 2 * i), bios_word[i], 1'b1));
			host_write(host_addr_t'(256 + 2 * i), bios_word[i]);
			step();
			step();                           // Idle cycle between strobes
			if (mem_req)
				note_failure("memory request during a BIOS download");
			if (cart_ready !== 1'b1)
				flag_mismatch("cart_ready", "1", $sformatf("%b", cart_ready));
		end
		dl_active = 1'b0;
		step();
		if (bios_q.size() != 0)
			note_failure("BIOS byte writes missing");
		report_test("BIOS download");

		// Two cheat codes
		dl_type = FT_CHEAT;
		dl_active = 1'b1;
		step();
		for (int c = 0; c < CHEAT_CODES; c++) begin
			for (int w = 0; w < 8; w++) begin
				if (w == 7)
					cheat_q.push_back(cheat_assemble(cheat_words[c]));
				host_write(host_addr_t'(16 * c + 2 * w), cheat_words[c][16*w +: 16]);
				step();
			end
		end
		dl_active = 1'b0;
		step();
		step();
		if (clear_count != 1)
			note_failure($sformatf("cheat_clear pulsed %0d times instead of once", clear_count));
		if (cheat_q.size() != 0)
			note_failure("cheat_valid missing for a code");
		report_test("cheat download");

		// Fast-forward with the monitor following the press history
		press_button(TB_HOLD + 20, 1'b1);     // Long hold
		press_button(5, 1'b1);                // Tap on
		repeat (10) step();
		press_button(5, 1'b1);                // Tap off
		osd_open = 1'b1;
		step();
		press_button(5, 1'b0);
		osd_open = 1'b0;
		step();
		dl_type = IDLE_TYPE;
		dl_active = 1'b1;
		step();
		press_button(5, 1'b0);
		dl_active = 1'b0;
		repeat (3) step();
		report_test("fast-forward");

		$display("Summary: %0d tests run, %0d errors", tests_done, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

/* compile.f */
+incdir+verification
logic/lynx_loader_pkg.sv
logic/cart_loader.sv
logic/bios_loader.sv
logic/cheat_loader.sv
logic/ff_latch.sv
logic/lynx_loader_top.sv
verification/loader_tb.sv

/* Makefile */
# Verilator lint and simulation of the loader testbench

VERILATOR  = verilator
TOP        = loader_tb
FILELIST   = compile.f
OBJ_DIR    = obj_dir
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert -j 0
PASS_TEXT  = All tests passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Fails unless the pass line shows up in the output
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
